// ==== Bender.yml ====
package:
  name: nora_debug

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/nora_pkg.sv
      - hdl/resetgen.sv
      - hdl/phaser.sv
      - hdl/spi_slave.sv
      - hdl/icd_controller.sv
      - hdl/bus_controller.sv
      - hdl/nora_top.sv
  - target: simulation
    files:
      - sim/tb_clkgen.sv
      - sim/tb_nora_top.sv

// ==== build.f ====
+incdir+hdl
hdl/nora_pkg.sv
hdl/resetgen.sv
hdl/phaser.sv
hdl/spi_slave.sv
hdl/icd_controller.sv
hdl/bus_controller.sv
hdl/nora_top.sv
sim/tb_clkgen.sv
sim/tb_nora_top.sv

// ==== hdl/bus_controller.sv ====
// External memory bus controller for debug requests
// Runs one SRAM cycle per request, framed by the phaser strobes
`timescale 1ns/1ps
`include "nora_config.svh"

module bus_controller (
    input  logic                    clk6x,
    input  logic                    resetn_i,
    input  logic                    setup_cs_i,
    input  logic                    release_cs_i,
    input  nora_pkg::nora_mst_req_t mst_req_i,
    output logic [7:0]              mst_datard_o,
    output logic                    mst_ack_o,
    output nora_pkg::mem_bus_t      mem_o,
    input  logic [7:0]              mem_db_i
);
    typedef enum logic [1:0] {
        ST_IDLE,    // No request
        ST_WAIT,    // Request seen, waiting for phase 0
        ST_ACTIVE   // SRAM cycle in progress
    } bus_state_t;

    bus_state_t state_q;
    bus_state_t state_d;
    logic       pending;        // Request not yet served
    logic       start;          // Access begins this cycle
    logic       active;         // Chip-select and strobe window
    logic       finish;         // Last phase of the access

    // Request is still high in the ack cycle, so mask it
    assign pending = mst_req_i.req_sram & ~mst_ack_o;
    assign start   = (state_q != ST_ACTIVE) & pending & setup_cs_i;
    assign active  = start | (state_q == ST_ACTIVE);
    assign finish  = (state_q == ST_ACTIVE) & release_cs_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (pending) state_d = setup_cs_i ? ST_ACTIVE : ST_WAIT;
            end
            ST_WAIT: begin
                if (setup_cs_i) state_d = ST_ACTIVE;
            end
            ST_ACTIVE: begin
                if (release_cs_i) state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk6x or negedge resetn_i) begin
        if (!resetn_i) begin
            state_q   <= ST_IDLE;
            mst_ack_o <= 1'b0;
        end else begin
            state_q   <= state_d;
            mst_ack_o <= finish;        // Same edge as data capture
        end
    end

    // SRAM read data sampled at the end of the access
    always_ff @(posedge clk6x) begin
        if (finish) mst_datard_o <= mem_db_i;
    end

    // Pin drive, upper address bits alias onto the SRAM
    always_comb begin
        mem_o.addr     = mst_req_i.addr[`NORA_SRAM_AW-1:0];
        mem_o.sram_csn = ~active;
        mem_o.rdn      = ~(active & mst_req_i.rwn);
        mem_o.wrn      = ~(active & ~mst_req_i.rwn);
        mem_o.db       = mst_req_i.datawr;
        mem_o.db_oe    = active & ~mst_req_i.rwn;  // Writes only
    end

endmodule

// ==== hdl/icd_controller.sv ====
// ICD frame decoder
// Turns header, address and data bytes from the SPI slave into SRAM requests
`timescale 1ns/1ps
`include "nora_config.svh"

module icd_controller (
    input  logic                    clk6x,
    input  logic                    resetn_i,
    input  nora_pkg::icd_rx_t       rx_i,
    output logic [7:0]              tx_byte_o,
    output logic                    tx_en_o,
    output nora_pkg::nora_mst_req_t mst_req_o,
    input  logic [7:0]              mst_datard_i,
    input  logic                    mst_ack_i
);
    import nora_pkg::*;

    typedef enum logic [2:0] {
        ST_HDR,     // Waiting for a header
        ST_ADH,     // Address bits 23:16
        ST_ADM,     // Address bits 15:8
        ST_ADL,     // Address bits 7:0
        ST_DATA,    // Data bytes
        ST_SKIP     // Unknown command, rest of frame ignored
    } icd_state_t;

    icd_state_t    state_q;
    logic          rd_q;        // Read frame
    nora_mst_req_t req_q;       // Outstanding request

    always_ff @(posedge clk6x or negedge resetn_i) begin
        if (!resetn_i) begin
            state_q <= ST_HDR;
            rd_q    <= 1'b0;
            req_q   <= '0;
            tx_en_o <= 1'b0;
        end else begin
            tx_en_o <= mst_ack_i & req_q.rwn;       // Read data to the slave
            // Access done
            if (mst_ack_i) begin
                req_q.req_sram <= 1'b0;
                req_q.addr     <= req_q.addr + 24'd1;   // Auto-increment
            end
            if (rx_i.hdr_en) begin
                // A new header restarts the frame
                case (rx_i.data)
                    `ICD_CMD_WRITE: begin
                        rd_q    <= 1'b0;
                        state_q <= ST_ADH;
                    end
                    `ICD_CMD_READ: begin
                        rd_q    <= 1'b1;
                        state_q <= ST_ADH;
                    end
                    default: state_q <= ST_SKIP;
                endcase
            end else if (rx_i.db_en) begin
                case (state_q)
                    ST_ADH: begin
                        req_q.addr[23:16] <= rx_i.data;
                        state_q           <= ST_ADM;
                    end
                    ST_ADM: begin
                        req_q.addr[15:8] <= rx_i.data;
                        state_q          <= ST_ADL;
                    end
                    ST_ADL: begin
                        req_q.addr[7:0] <= rx_i.data;
                        state_q         <= ST_DATA;
                        // First read goes out right away
                        if (rd_q) begin
                            req_q.rwn      <= 1'b1;
                            req_q.req_sram <= 1'b1;
                        end
                    end
                    ST_DATA: begin
                        req_q.rwn      <= rd_q;
                        req_q.req_sram <= 1'b1;     // Write or next prefetch
                        if (!rd_q) req_q.datawr <= rx_i.data;
                    end
                    default: ;                      // Header wait or skip
                endcase
            end
        end
    end

    // Reply byte, valid with tx_en_o
    always_ff @(posedge clk6x) begin
        if (mst_ack_i) tx_byte_o <= mst_datard_i;
    end

    assign mst_req_o = req_q;

endmodule

// ==== hdl/nora_config.svh ====
// Build-time constants of the debug path
// Included by the package and by every RTL block that needs a constant
`ifndef NORA_CONFIG_SVH
`define NORA_CONFIG_SVH

// Internal reset hold after the synchronized release, in clk6x cycles
`define NORA_RESET_HOLD 8

`define NORA_SRAM_AW 21         // External SRAM address width

`define ICD_CMD_WRITE 8'h01     // Frame header for SRAM write
`define ICD_CMD_READ 8'h02      // Frame header for SRAM read

`define NORA_PHASES 6           // clk6x cycles per CPU cycle

`endif

// ==== hdl/nora_pkg.sv ====
// Struct types shared by the debug path blocks
// Ports use scoped names, module bodies import what they declare
`include "nora_config.svh"

package nora_pkg;

    // Debug master request toward the bus controller
    // Held as a level until the ack pulse
    typedef struct packed {
        logic [23:0] addr;      // CPU-side 24-bit address
        logic [7:0]  datawr;    // Write data
        logic        rwn;       // High for read
        logic        req_sram;  // SRAM request level
    } nora_mst_req_t;

    // One byte out of the SPI slave
    typedef struct packed {
        logic [7:0] data;       // Received byte
        logic       hdr_en;     // First byte of frame
        logic       db_en;      // Any later byte
    } icd_rx_t;

    // External memory bus outputs
    typedef struct packed {
        logic [`NORA_SRAM_AW-1:0] addr;     // SRAM address
        logic                     sram_csn; // SRAM chip-select, active low
        logic                     rdn;      // Read strobe
        logic                     wrn;      // Write strobe
        logic [7:0]               db;       // Data toward memory
        logic                     db_oe;    // Data bus drive enable
    } mem_bus_t;

endpackage

// ==== hdl/nora_top.sv ====
// Top level of the debug path
// SPI debugger port in, external SRAM bus and CPU phase clock out
`timescale 1ns/1ps

module nora_top (
    input  logic               clk6x,          // Fast clock straight from the pin
    input  logic               rst_n_i,
    input  logic               icd_sck_i,
    input  logic               icd_csn_i,
    input  logic               icd_mosi_i,
    output logic               icd_miso_o,
    output logic               icd_miso_oe_o,
    output logic               cphi2_o,
    output nora_pkg::mem_bus_t mem_o,
    input  logic [7:0]         mem_db_i
);
    import nora_pkg::*;

    logic          resetn;          // Internal reset, clk6x domain
    logic          setup_cs;        // Phase 0 of each CPU cycle
    logic          release_cs;      // Last phase of each CPU cycle
    icd_rx_t       icd_rx;
    logic [7:0]    icd_tx_byte;
    logic          icd_tx_en;
    nora_mst_req_t nora_mst_req;
    logic [7:0]    nora_mst_datard;
    logic          nora_mst_ack;    // End of access, read data valid

    resetgen rstgen0 (
        .clk6x    (clk6x),
        .rst_n_i  (rst_n_i),
        .resetn_o (resetn)
    );

    phaser ph0 (
        .clk6x        (clk6x),
        .resetn_i     (resetn),
        .cphi2_o      (cphi2_o),
        .setup_cs_o   (setup_cs),
        .release_cs_o (release_cs)
    );

    spi_slave icdspi (
        .clk6x            (clk6x),
        .resetn_i         (resetn),
        .spi_clk_i        (icd_sck_i),
        .spi_csn_i        (icd_csn_i),
        .spi_mosi_i       (icd_mosi_i),
        .spi_miso_o       (icd_miso_o),
        .spi_miso_drive_o (icd_miso_oe_o),  // Pad tristate control
        .rx_o             (icd_rx),
        .tx_byte_i        (icd_tx_byte),
        .tx_en_i          (icd_tx_en)
    );

    icd_controller icdctrl (
        .clk6x        (clk6x),
        .resetn_i     (resetn),
        .rx_i         (icd_rx),
        .tx_byte_o    (icd_tx_byte),
        .tx_en_o      (icd_tx_en),
        .mst_req_o    (nora_mst_req),
        .mst_datard_i (nora_mst_datard),
        .mst_ack_i    (nora_mst_ack)
    );

    bus_controller busctrl0 (
        .clk6x        (clk6x),
        .resetn_i     (resetn),
        .setup_cs_i   (setup_cs),
        .release_cs_i (release_cs),
        .mst_req_i    (nora_mst_req),
        .mst_datard_o (nora_mst_datard),
        .mst_ack_o    (nora_mst_ack),
        .mem_o        (mem_o),
        .mem_db_i     (mem_db_i)       // SRAM data back in
    );

endmodule

// ==== hdl/phaser.sv ====
// CPU cycle phaser
// Splits clk6x into CPU cycles and gives the bus controller its chip-select timing
`timescale 1ns/1ps
`include "nora_config.svh"

module phaser (
    input  logic clk6x,
    input  logic resetn_i,
    output logic cphi2_o,       // CPU phase clock, high in second half
    output logic setup_cs_o,    // Phase 0 strobe
    output logic release_cs_o   // Last phase strobe
);
    localparam int unsigned PH = `NORA_PHASES;
    localparam int unsigned PW = $clog2(PH);
    localparam logic [PW-1:0] LAST = PW'(PH - 1);
    localparam logic [PW-1:0] HALF = PW'(PH / 2);

    logic [PW-1:0] phase_q;     // Current phase
    logic [PW-1:0] phase_nxt;

    // Wrap at the last phase
    always_comb begin
        if (phase_q == LAST) begin
            phase_nxt = '0;
        end else begin
            phase_nxt = phase_q + 1'b1;
        end
    end

    // Outputs decoded from the next phase
    // so they line up with phase_q and stay glitch free
    always_ff @(posedge clk6x or negedge resetn_i) begin
        if (!resetn_i) begin
            phase_q      <= LAST;   // First cycle after reset is phase 0
            cphi2_o      <= 1'b0;
            setup_cs_o   <= 1'b0;
            release_cs_o <= 1'b0;
        end else begin
            phase_q      <= phase_nxt;
            cphi2_o      <= (phase_nxt >= HALF);   // Phases 3 to 5
            setup_cs_o   <= (phase_nxt == '0);
            release_cs_o <= (phase_nxt == LAST);
        end
    end

endmodule

// ==== hdl/resetgen.sv ====
// Reset generator for the clk6x domain
// Takes the board reset and releases the internal reset after a fixed hold
`timescale 1ns/1ps
`include "nora_config.svh"

module resetgen (
    input  logic clk6x,
    input  logic rst_n_i,
    output logic resetn_o
);
    localparam int unsigned HOLD = `NORA_RESET_HOLD;
    localparam int unsigned CW = $clog2(HOLD + 1);

    logic [1:0]    sync_q;      // Async assert, sync release
    logic [CW-1:0] hold_cnt_q;  // Cycles since synchronized release

    always_ff @(posedge clk6x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q     <= 2'b00;
            hold_cnt_q <= '0;
            resetn_o   <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
            if (!sync_q[1]) begin
                hold_cnt_q <= '0;
                resetn_o   <= 1'b0;
            end else if (hold_cnt_q == CW'(HOLD - 1)) begin
                resetn_o <= 1'b1;                   // Counter parks here
            end else begin
                hold_cnt_q <= hold_cnt_q + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/spi_slave.sv ====
// SPI mode-0 slave for the ICD port, oversampled in clk6x
// Frames bytes for the ICD controller and shifts its reply bytes out on MISO
`timescale 1ns/1ps

module spi_slave (
    input  logic              clk6x,
    input  logic              resetn_i,
    input  logic              spi_clk_i,
    input  logic              spi_csn_i,
    input  logic              spi_mosi_i,
    output logic              spi_miso_o,
    output logic              spi_miso_drive_o,
    output nora_pkg::icd_rx_t rx_o,
    input  logic [7:0]        tx_byte_i,
    input  logic              tx_en_i
);
    logic [2:0] sck_q;          // Bit 2 is the previous sample
    logic [1:0] csn_q;
    logic [1:0] mosi_q;
    logic       sck_rise;
    logic       sck_fall;
    logic       csn_hi;         // Frame inactive
    logic       byte_done;      // Eighth rising edge
    logic [2:0] bit_cnt_q;
    logic       got_hdr_q;      // Header already received in this frame
    logic [6:0] rx_sh_q;        // First seven bits, MSB first
    logic [7:0] tx_sh_q;        // MISO shifter, MSB on the pin
    logic [7:0] rx_byte_q;
    logic       rx_hdr_q;
    logic       rx_db_q;

    assign sck_rise  = sck_q[1] & ~sck_q[2];
    assign sck_fall  = ~sck_q[1] & sck_q[2];
    assign csn_hi    = csn_q[1];
    assign byte_done = sck_rise & ~csn_hi & (bit_cnt_q == 3'd7);

    // Two-flop synchronizers, same depth for all pins
    always_ff @(posedge clk6x or negedge resetn_i) begin
        if (!resetn_i) begin
            sck_q  <= '0;
            csn_q  <= '1;       // Deselected
            mosi_q <= '0;
        end else begin
            sck_q  <= {sck_q[1:0], spi_clk_i};
            csn_q  <= {csn_q[0], spi_csn_i};
            mosi_q <= {mosi_q[0], spi_mosi_i};
        end
    end

    // Bit counter, frame flags and MISO shifter
    always_ff @(posedge clk6x or negedge resetn_i) begin
        if (!resetn_i) begin
            bit_cnt_q <= '0;
            got_hdr_q <= 1'b0;
            tx_sh_q   <= '0;
            rx_hdr_q  <= 1'b0;
            rx_db_q   <= 1'b0;
        end else begin
            rx_hdr_q <= byte_done & ~got_hdr_q;
            rx_db_q  <= byte_done & got_hdr_q;
            if (csn_hi) begin
                bit_cnt_q <= '0;            // Partial byte dropped
                got_hdr_q <= 1'b0;
                tx_sh_q   <= '0;
            end else begin
                if (sck_rise) bit_cnt_q <= bit_cnt_q + 1'b1;   // Wraps every byte
                if (byte_done) got_hdr_q <= 1'b1;
                // Shift only inside a byte, not on the trailing falling edge
                if (sck_fall && bit_cnt_q != 3'd0) tx_sh_q <= {tx_sh_q[6:0], 1'b0};
                if (byte_done) tx_sh_q <= '0;               // Zeros unless reloaded
                if (tx_en_i) tx_sh_q <= tx_byte_i;          // Reply for next byte
            end
        end
    end

    // Received data path
    always_ff @(posedge clk6x) begin
        if (sck_rise) rx_sh_q <= {rx_sh_q[5:0], mosi_q[1]};
        if (byte_done) rx_byte_q <= {rx_sh_q, mosi_q[1]};
    end

    assign rx_o = '{data: rx_byte_q, hdr_en: rx_hdr_q, db_en: rx_db_q};

    assign spi_miso_o       = tx_sh_q[7];
    assign spi_miso_drive_o = ~csn_hi;      // Drive for the whole frame

endmodule

// ==== sim/tb_clkgen.sv ====
// Free-running testbench clock, stands in for the clk6x pin
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk_o
);
    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;  // 50% duty

endmodule

// ==== sim/tb_nora_top.sv ====
// Testbench for the debug path with an SPI debugger model, SRAM model and reference memory
// Runs six directed tests on random addresses and data, then prints a summary line
`timescale 1ns/1ps
`include "nora_config.svh"

module tb_nora_top;
    import nora_pkg::*;

    localparam int AW = `NORA_SRAM_AW;

    typedef struct packed {
        logic [AW-1:0] addr;
        logic [7:0]    data;
    } wr_exp_t;                                 // Predicted SRAM write

    logic        clk;
    logic        rst_n;
    logic        icd_sck;
    logic        icd_csn;
    logic        icd_mosi;
    logic        icd_miso;
    logic        icd_miso_oe;
    logic        cphi2;
    mem_bus_t    mem_bus;
    logic [7:0]  mem_db = 8'hff;
    logic        mem_wrn;
    logic        mem_csn;
    logic [7:0]  sram [logic [AW-1:0]];         // SRAM model
    logic [7:0]  ref_mem [logic [AW-1:0]];      // Predicted contents
    wr_exp_t     wr_exp_q [$];
    logic [31:0] rng;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cs_count = 0;                  // Chip-select assertions
    int          limit = 0;                     // Timeout in cycles
    int          cycles = 0;

    tb_clkgen clkgen_i (.clk_o(clk));

    nora_top nora_top_i (
        .clk6x(clk),            .rst_n_i(rst_n),
        .icd_sck_i(icd_sck),    .icd_csn_i(icd_csn),
        .icd_mosi_i(icd_mosi),  .icd_miso_o(icd_miso),
        .icd_miso_oe_o(icd_miso_oe),
        .cphi2_o(cphi2),        .mem_o(mem_bus),
        .mem_db_i(mem_db)
    );

    assign mem_wrn = mem_bus.wrn;
    assign mem_csn = mem_bus.sram_csn;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Never-written cells read back a pattern of the whole address
    function automatic logic [7:0] fill_byte(input logic [AW-1:0] a);
        return a[7:0] ^ a[15:8] ^ {3'b000, a[20:16]};
    endfunction

    function automatic logic [7:0] sram_byte(input logic [AW-1:0] a);
        return sram.exists(a) ? sram[a] : fill_byte(a);
    endfunction

    function automatic logic [7:0] predicted(input logic [AW-1:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
        n_checks++;
        assert (got === want) else begin
            n_errors++;
            $display("FAIL @%0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic require(input logic cond, input string what);
        n_checks++;
        assert (cond === 1'b1) else begin
            n_errors++;
            $display("at %0t: %s", $time, what);
        end
    endtask

    task automatic report(input int num, input string name, input int errs_before);
        if (n_errors == errs_before)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, n_errors - errs_before);
    endtask

    task automatic check_quiet(input logic in_reset);
        require(mem_bus.sram_csn && mem_bus.rdn && mem_bus.wrn, "SRAM strobe active while idle");
        require(!mem_bus.db_oe && !icd_miso_oe, "output enable on while idle");
        if (in_reset)
            require(!cphi2, "cphi2 high during reset");
    endtask

    // Mode 0, SCK period 8 cycles, gap leaves room for the read prefetch
    task automatic shift_byte(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
        int i;
        rx = '0;
        for (i = 7; i > 7 - nbits; i--) begin
            icd_mosi = tx[i];
            repeat (4) @(negedge clk);
            rx[i] = icd_miso;                   // Sampled as SCK rises
            require(icd_miso_oe, "MISO not driven inside a frame");
            icd_sck = 1'b1;
            repeat (4) @(negedge clk);
            icd_sck = 1'b0;
        end
        repeat (16) @(negedge clk);
    endtask

    task automatic open_frame(input logic [7:0] cmd, input logic [23:0] addr);
        logic [7:0] unused;
        @(negedge clk);
        icd_csn = 1'b0;
        repeat (4) @(negedge clk);
        shift_byte(cmd, 8, unused);
        shift_byte(addr[23:16], 8, unused);     // High byte first
        shift_byte(addr[15:8], 8, unused);
        shift_byte(addr[7:0], 8, unused);
    endtask

    task automatic close_frame();
        repeat (8) @(negedge clk);
        icd_csn = 1'b1;
        repeat (30) @(negedge clk);             // Trailing prefetch ends in here
    endtask

    task automatic write_burst(input logic [23:0] addr, input int n);
        logic [7:0]  unused;
        logic [23:0] full;
        int          k;
        open_frame(`ICD_CMD_WRITE, addr);
        for (k = 0; k < n; k++) begin
            rng = xorshift32(rng);
            full = addr + 24'(k);               // Auto-increment, top bits alias
            ref_mem[full[AW-1:0]] = rng[7:0];
            wr_exp_q.push_back(wr_exp_t'{addr: full[AW-1:0], data: rng[7:0]});
            shift_byte(rng[7:0], 8, unused);
        end
        close_frame();
        require(wr_exp_q.size() == 0, "predicted SRAM write never happened");
        for (k = 0; k < n; k++) begin
            full = addr + 24'(k);
            compare(sram_byte(full[AW-1:0]), predicted(full[AW-1:0]), "SRAM byte after write");
        end
    endtask

    task automatic read_burst(input logic [23:0] addr, input int n);
        logic [7:0]  got;
        logic [23:0] full;
        int          k;
        open_frame(`ICD_CMD_READ, addr);
        for (k = 0; k < n; k++) begin
            full = addr + 24'(k);
            shift_byte(8'h00, 8, got);
            compare(got, predicted(full[AW-1:0]), "read byte on MISO");
        end
        close_frame();
    endtask

    // SRAM write on the trailing edge of the strobe
    always @(posedge mem_wrn) begin : sram_write
        wr_exp_t want;
        if (rst_n) begin
            sram[mem_bus.addr] = mem_bus.db;
            require(wr_exp_q.size() > 0, "SRAM write with no write predicted");
            if (wr_exp_q.size() > 0) begin
                want = wr_exp_q.pop_front();
                compare(mem_bus.addr, want.addr, "SRAM write address");
                compare(mem_bus.db, want.data, "SRAM write data");
            end
        end
    end

    always @(negedge mem_csn) begin
        if (rst_n)
            cs_count++;
    end

    always @(negedge clk) begin
        if (mem_bus.rdn === 1'b0)
            mem_db = sram_byte(mem_bus.addr);
        else
            mem_db = 8'hff;                     // Bus floats high
        if (mem_bus.rdn === 1'b0 || mem_bus.wrn === 1'b0)
            require(mem_bus.sram_csn === 1'b0, "SRAM strobe without chip-select");
        if (mem_bus.wrn === 1'b0)
            require(mem_bus.db_oe === 1'b1, "data bus not driven during SRAM write");
    end

    initial begin : watchdog
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        logic [23:0] base;
        logic [7:0]  unused;
        logic        prev_phi;
        int          n_wr;
        int          errs;
        int          cyc;
        int          rise_at;
        int          periods;
        rst_n = 1'b0;
        icd_sck = 1'b0;
        icd_csn = 1'b1;
        icd_mosi = 1'b0;
        rng = xorshift32(32'h23730a81);
        n_wr = 2 + int'(rng % 11);
        limit = (2 * n_wr + 42) * 64 + 2000;    // Frame bytes of all tests

        errs = n_errors;
        for (cyc = 0; cyc < 16; cyc++) begin
            @(negedge clk);
            if (cyc >= 2)
                check_quiet(1'b1);
        end
        rst_n = 1'b1;
        rise_at = -1;
        periods = 0;
        prev_phi = 1'b0;
        for (cyc = 0; cyc < 60; cyc++) begin
            @(negedge clk);
            check_quiet(1'b0);
            if (cphi2 && !prev_phi) begin
                if (rise_at >= 0) begin
                    compare(cyc - rise_at, 6, "cphi2 period in cycles");
                    periods++;
                end
                rise_at = cyc;
            end
            prev_phi = cphi2;
        end
        require(periods >= 5, "cphi2 does not run after reset");
        report(1, "reset and phaser", errs);

        errs = n_errors;
        rng = xorshift32(rng);
        base = {3'b000, rng[20:0]};
        write_burst(base, n_wr);
        report(2, "write burst", errs);
        errs = n_errors;
        read_burst(base, n_wr);
        report(3, "read burst", errs);

        errs = n_errors;
        rng = xorshift32(rng);
        base = {3'b111, rng[20:0]};
        write_burst(base, 2);
        read_burst({3'b101, base[20:0]}, 2);    // Other upper bits, same cells
        report(4, "address alias", errs);

        errs = n_errors;
        cyc = cs_count;
        open_frame(8'h5a, 24'h000000);
        shift_byte(8'h3c, 8, unused);
        close_frame();
        compare(cs_count, cyc, "chip-select count after unknown header");
        report(5, "unknown header", errs);

        errs = n_errors;
        cyc = cs_count;
        rng = xorshift32(rng);
        base = {3'b000, rng[20:0]};
        open_frame(`ICD_CMD_WRITE, base);
        shift_byte(rng[31:24], 4, unused);      // Cut after half a data byte
        close_frame();
        compare(cs_count, cyc, "chip-select count after aborted frame");
        write_burst(base, 2);
        read_burst(base, 2);
        report(6, "aborted frame", errs);

        $display("tests 6, checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
